// File: design/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // Field widths
    localparam int PADR_W    = 15;
    localparam int WORD_W    = 32;
    localparam int SLOTS     = 4;
    localparam int LINE_W    = WORD_W * SLOTS;
    localparam int UNIT_W    = 4;
    localparam int NWORDS_W  = 3;

    localparam int N_SRC     = 2;   // Source units on the bus
    localparam int N_DES     = 2;   // Destination units on the bus
    localparam int SRC_IDX_W = $clog2(N_SRC);

    typedef logic [PADR_W-1:0]    padr_t;
    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [LINE_W-1:0]    line_t;      // Four word slots with slot 0 in the low bits
    typedef logic [UNIT_W-1:0]    unit_id_t;
    typedef logic [SLOTS-1:0]     slot_mask_t; // One-hot with bit 0 on the last beat
    typedef logic [NWORDS_W-1:0]  nwords_t;
    typedef logic [SRC_IDX_W-1:0] src_idx_t;

    typedef struct packed {
        padr_t    padr;
        unit_id_t ret;   // Unit that issued the packet
        unit_id_t dest;
        logic     rw;
    } pkt_hdr_t;

    typedef struct packed {
        pkt_hdr_t hdr;
        line_t    data;
        nwords_t  nwords;
    } pkt_req_t;

    typedef struct packed {
        logic       valid;
        pkt_hdr_t   hdr;
        word_t      word;
        slot_mask_t slot;
    } bus_beat_t;

    typedef struct packed {
        pkt_hdr_t hdr;
        line_t    data;
        nwords_t  nwords;
    } pkt_out_t;

    // One-hot with bits for free, receiving and full
    typedef enum logic [2:0] {
        DES_FREE = 3'b001,
        DES_RECV = 3'b010,
        DES_FULL = 3'b100
    } des_state_e;

endpackage

`default_nettype wire

// File: design/bus_src.sv
`timescale 1ns/1ps
`default_nettype none

module bus_src (
    input  logic                clk_bus,
    input  logic                rst_n,
    input  logic                send,
    input  bus_pkg::pkt_req_t   req,
    output logic                busy,
    output logic                bus_req,
    output bus_pkg::unit_id_t   req_dest,
    input  logic                grant,
    output bus_pkg::bus_beat_t  beat
);

    bus_pkg::pkt_req_t held;        // Packet copied from the block
    bus_pkg::nwords_t  cur;         // Slot index of the current beat
    logic              beat_valid;
    logic              take;
    logic              last_beat;

    assign take      = send && !busy;
    assign last_beat = beat_valid && (cur == '0);

    // Packet payload loaded once per send
    always_ff @(posedge clk_bus) begin
        if (take) begin
            held <= req;
        end
    end

    always_ff @(posedge clk_bus) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            bus_req    <= 1'b0;
            beat_valid <= 1'b0;
            cur        <= '0;
        end else begin
            if (take) begin
                busy    <= 1'b1;
                bus_req <= 1'b1;   // Ask the bau next cycle
            end else if (last_beat) begin
                busy <= 1'b0;
            end

            if (grant) begin
                // Start from the highest used slot
                bus_req    <= 1'b0;
                beat_valid <= 1'b1;
                cur        <= held.nwords - 1'b1;
            end else if (last_beat) begin
                beat_valid <= 1'b0;
            end else if (beat_valid) begin
                cur <= cur - 1'b1;   // Step down towards slot 0
            end
        end
    end

    assign req_dest = held.hdr.dest;

    // Beat is built from the held packet and the slot counter
    always_comb begin
        beat.valid = beat_valid;
        beat.hdr   = held.hdr;
        beat.word  = held.data[cur*bus_pkg::WORD_W +: bus_pkg::WORD_W];
        beat.slot  = bus_pkg::slot_mask_t'(1) << cur;
    end

endmodule

`default_nettype wire

// File: design/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic                        clk_bus,
    input  logic                        rst_n,
    input  logic [bus_pkg::N_SRC-1:0]   bus_req,
    input  bus_pkg::unit_id_t           req_dest [bus_pkg::N_SRC],
    input  bus_pkg::bus_beat_t          beat [bus_pkg::N_SRC],
    input  logic [bus_pkg::N_DES-1:0]   free,
    output logic [bus_pkg::N_SRC-1:0]   grant,
    output logic [bus_pkg::N_DES-1:0]   set_receiver,
    output bus_pkg::bus_beat_t          bus
);

    logic [bus_pkg::N_SRC-1:0] eligible;   // Requesting and destination free
    bus_pkg::src_idx_t         last;       // Last winner
    bus_pkg::src_idx_t         owner;
    logic                      owned;
    bus_pkg::src_idx_t         pick;
    logic                      pick_valid;

    always_comb begin
        eligible = '0;
        for (int i = 0; i < bus_pkg::N_SRC; i++) begin
            for (int d = 0; d < bus_pkg::N_DES; d++) begin
                if (bus_req[i] && req_dest[i] == bus_pkg::unit_id_t'(d) && free[d]) begin
                    eligible[i] = 1'b1;
                end
            end
        end
    end

    // Round-robin scan where the source right after last wins
    always_comb begin
        int idx;
        pick       = last;
        pick_valid = 1'b0;
        for (int k = bus_pkg::N_SRC; k >= 1; k--) begin
            idx = (int'(last) + k) % bus_pkg::N_SRC;
            if (eligible[idx]) begin
                pick       = bus_pkg::src_idx_t'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_bus) begin
        if (!rst_n) begin
            grant        <= '0;
            set_receiver <= '0;
            owned        <= 1'b0;
            owner        <= '0;
            last         <= bus_pkg::src_idx_t'(bus_pkg::N_SRC - 1);
        end else begin
            grant        <= '0;   // Pulses only
            set_receiver <= '0;
            if (!owned && pick_valid) begin
                grant[pick] <= 1'b1;
                for (int d = 0; d < bus_pkg::N_DES; d++) begin
                    set_receiver[d] <= (req_dest[pick] == bus_pkg::unit_id_t'(d));
                end
                owned <= 1'b1;
                owner <= pick;
                last  <= pick;
            end else if (owned && bus.valid && bus.slot[0]) begin
                owned <= 1'b0;   // Last beat seen
            end
        end
    end

    // Idle bus carries a beat with valid low
    always_comb begin
        bus = '0;
        if (owned) begin
            bus = beat[owner];
        end
    end

endmodule

`default_nettype wire

// File: design/bus_des.sv
`timescale 1ns/1ps
`default_nettype none

module bus_des #(
    parameter int loc = 0
) (
    input  logic                clk_bus,
    input  logic                rst_n,
    input  logic                set_receiver,
    input  bus_pkg::bus_beat_t  bus,
    output logic                free,
    output logic                full,
    input  logic                read,
    output bus_pkg::pkt_out_t   pkt
);

    bus_pkg::des_state_e state;
    bus_pkg::des_state_e state_next;
    logic                hit;   // Beat for this unit while receiving

    assign hit = (state == bus_pkg::DES_RECV) && bus.valid &&
                 (bus.hdr.dest == bus_pkg::unit_id_t'(loc));

    always_comb begin
        state_next = state;
        case (state)
            bus_pkg::DES_FREE: begin
                if (set_receiver) begin
                    state_next = bus_pkg::DES_RECV;
                end
            end
            bus_pkg::DES_RECV: begin
                if (hit && bus.slot[0]) begin
                    state_next = bus_pkg::DES_FULL;   // Slot 0 closes the packet
                end
            end
            bus_pkg::DES_FULL: begin
                if (read) begin
                    state_next = bus_pkg::DES_FREE;
                end
            end
            default: state_next = bus_pkg::DES_FREE;
        endcase
    end

    always_ff @(posedge clk_bus) begin
        if (!rst_n) begin
            state <= bus_pkg::DES_FREE;
        end else begin
            state <= state_next;
        end
    end

    // Packet buffer
    always_ff @(posedge clk_bus) begin
        if (!rst_n) begin
            pkt <= '0;
        end else if (state == bus_pkg::DES_FREE && set_receiver) begin
            pkt.nwords <= '0;   // Fresh count for the coming packet
        end else if (hit) begin
            pkt.hdr    <= bus.hdr;
            pkt.nwords <= pkt.nwords + 1'b1;
            for (int s = 0; s < bus_pkg::SLOTS; s++) begin
                // Unnamed slots keep their old words
                if (bus.slot[s]) begin
                    pkt.data[s*bus_pkg::WORD_W +: bus_pkg::WORD_W] <= bus.word;
                end
            end
        end
    end

    assign free = (state == bus_pkg::DES_FREE);
    assign full = (state == bus_pkg::DES_FULL);

endmodule

`default_nettype wire

// File: design/bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_top (
    input  logic                        clk_bus,
    input  logic                        rst_n,
    input  logic [bus_pkg::N_SRC-1:0]   send,
    input  bus_pkg::pkt_req_t           req [bus_pkg::N_SRC],
    output logic [bus_pkg::N_SRC-1:0]   busy,
    input  logic [bus_pkg::N_DES-1:0]   read,
    output logic [bus_pkg::N_DES-1:0]   full,
    output bus_pkg::pkt_out_t           pkt [bus_pkg::N_DES]
);

    logic [bus_pkg::N_SRC-1:0] bus_req;
    logic [bus_pkg::N_SRC-1:0] grant;
    bus_pkg::unit_id_t         req_dest [bus_pkg::N_SRC];
    bus_pkg::bus_beat_t        beat [bus_pkg::N_SRC];
    logic [bus_pkg::N_DES-1:0] free;
    logic [bus_pkg::N_DES-1:0] set_receiver;
    bus_pkg::bus_beat_t        bus;   // Shared by all destinations

    for (genvar i = 0; i < bus_pkg::N_SRC; i++) begin : g_src
        bus_src u_src (
            .clk_bus  (clk_bus),
            .rst_n    (rst_n),
            .send     (send[i]),
            .req      (req[i]),
            .busy     (busy[i]),
            .bus_req  (bus_req[i]),
            .req_dest (req_dest[i]),
            .grant    (grant[i]),
            .beat     (beat[i])
        );
    end

    bus_arbiter u_bau (
        .clk_bus      (clk_bus),
        .rst_n        (rst_n),
        .bus_req      (bus_req),
        .req_dest     (req_dest),
        .beat         (beat),
        .free         (free),
        .grant        (grant),
        .set_receiver (set_receiver),
        .bus          (bus)
    );

    // Unit number follows the instance index
    for (genvar j = 0; j < bus_pkg::N_DES; j++) begin : g_des
        bus_des #(
            .loc (j)
        ) u_des (
            .clk_bus      (clk_bus),
            .rst_n        (rst_n),
            .set_receiver (set_receiver[j]),
            .bus          (bus),
            .free         (free[j]),
            .full         (full[j]),
            .read         (read[j]),
            .pkt          (pkt[j])
        );
    end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_bus,
    output logic rst_n
);

    initial begin
        clk_bus = 1'b0;
        forever #2 clk_bus = ~clk_bus;   // 4 ns period
    end

    // Reset held over two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk_bus);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/bus_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module bus_asserts (
    input logic                      clk_bus,
    input logic                      rst_n,
    input logic [bus_pkg::N_SRC-1:0] grant,
    input logic [bus_pkg::N_DES-1:0] set_receiver,
    input logic [bus_pkg::N_DES-1:0] free,
    input logic [bus_pkg::N_DES-1:0] full
);

    // At most one source owns the bus
    a_grant_onehot: assert property (@(posedge clk_bus) disable iff (!rst_n)
        $onehot0(grant))
        else $error("grant has more than one bit set");

    a_arm_free: assert property (@(posedge clk_bus) disable iff (!rst_n)
        (set_receiver & ~free) == '0)
        else $error("set_receiver went to a destination that is not free");

    a_full_free: assert property (@(posedge clk_bus) disable iff (!rst_n)
        (full & free) == '0)
        else $error("destination reports full and free together");

endmodule

bind bus_top bus_asserts u_asserts (
    .clk_bus      (clk_bus),
    .rst_n        (rst_n),
    .grant        (grant),
    .set_receiver (set_receiver),
    .free         (free),
    .full         (full)
);

`default_nettype wire

// File: bench/bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bus_tb;

    localparam int ROUNDS    = 3;   // Shared destination rounds in test 4
    localparam int RAND_PKTS = 40;
    localparam int MAX_GAP   = 3;
    localparam int MAX_DELAY = 5;   // Longest read delay
    localparam int DEPTH     = 64;
    localparam int N_PKTS    = 1 + 3 + 2 + 2 * ROUNDS + RAND_PKTS;
    localparam int TIMEOUT   = N_PKTS * (bus_pkg::SLOTS + 6 + MAX_DELAY + MAX_GAP) + 100;

    logic                      clk_bus;
    logic                      rst_n;
    logic [bus_pkg::N_SRC-1:0] send;
    bus_pkg::pkt_req_t         req [bus_pkg::N_SRC];
    logic [bus_pkg::N_SRC-1:0] busy;
    logic [bus_pkg::N_DES-1:0] read;
    logic [bus_pkg::N_DES-1:0] full;
    bus_pkg::pkt_out_t         pkt [bus_pkg::N_DES];

    bus_pkg::pkt_req_t sent [bus_pkg::N_SRC][DEPTH];   // Per source in send order
    int                head [bus_pkg::N_SRC];
    int                tail [bus_pkg::N_SRC];
    bus_pkg::line_t    line_model [bus_pkg::N_DES];
    int                arr_src [bus_pkg::N_DES][DEPTH];
    int                rise_at [bus_pkg::N_DES][DEPTH];
    int                read_at [bus_pkg::N_DES][DEPTH];
    int                n_arr [bus_pkg::N_DES];
    int                cycle;
    int                errors;
    int                checks;
    int                tests;
    int                test_errors;
    int                total_sent;
    int                delivered;

    tb_clock u_clock (.clk_bus(clk_bus), .rst_n(rst_n));

    bus_top dut (
        .clk_bus (clk_bus),
        .rst_n   (rst_n),
        .send    (send),
        .req     (req),
        .busy    (busy),
        .read    (read),
        .full    (full),
        .pkt     (pkt)
    );

    always @(posedge clk_bus) begin
        cycle <= cycle + 1;
        if (cycle > TIMEOUT) begin
            $display("Timeout after %0d cycles, %0d of %0d packets delivered",
                     cycle, delivered, total_sent);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_equal(input string name, input logic [159:0] got,
                               input logic [159:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    // Sent words land in slots nwords-1..0 and the rest keep the old buffer
    function automatic bus_pkg::pkt_out_t ref_packet(input bus_pkg::pkt_req_t r,
                                                     input bus_pkg::line_t prev);
        bus_pkg::pkt_out_t e;
        e.hdr    = r.hdr;
        e.nwords = r.nwords;
        e.data   = prev;
        for (int s = 0; s < bus_pkg::SLOTS; s++) begin
            if (s < int'(r.nwords)) begin
                e.data[s*bus_pkg::WORD_W +: bus_pkg::WORD_W] =
                    r.data[s*bus_pkg::WORD_W +: bus_pkg::WORD_W];
            end
        end
        return e;
    endfunction

    function automatic bus_pkg::pkt_req_t rand_req(input int src, input int dest, input int n);
        bus_pkg::pkt_req_t r;
        r.hdr.padr = bus_pkg::padr_t'($urandom);
        r.hdr.ret  = bus_pkg::unit_id_t'(src);   // Marks the sending source
        r.hdr.dest = bus_pkg::unit_id_t'(dest);
        r.hdr.rw   = $urandom % 2;
        r.data     = {$urandom, $urandom, $urandom, $urandom};
        r.nwords   = bus_pkg::nwords_t'(n);
        return r;
    endfunction

    task automatic send_pkt(input int src, input bus_pkg::pkt_req_t r, output int at);
        @(posedge clk_bus);
        while (busy[src]) begin
            @(posedge clk_bus);
        end
        send[src] <= 1'b1;
        req[src]  <= r;
        at = cycle;
        sent[src][tail[src]] = r;
        tail[src]++;
        total_sent++;
        @(posedge clk_bus);
        send[src] <= 1'b0;
    endtask

    task automatic wait_all();
        while (delivered < total_sent) begin
            @(posedge clk_bus);
        end
    endtask

    // Compare process for one destination
    task automatic serve_dest(input int d);
        bus_pkg::pkt_out_t exp;
        int src;
        forever begin
            @(posedge clk_bus);
            if (full[d]) begin
                src = int'(pkt[d].hdr.ret);
                rise_at[d][n_arr[d]] = cycle - 1;   // full was set at the previous edge
                arr_src[d][n_arr[d]] = src;
                if (src >= bus_pkg::N_SRC || head[src] == tail[src]) begin
                    errors++;
                    $display("Destination %0d filled with no packet pending from source %0d",
                             d, src);
                end else begin
                    exp = ref_packet(sent[src][head[src]], line_model[d]);
                    head[src]++;
                    line_model[d] = exp.data;
                    check_equal("pkt.hdr", pkt[d].hdr, exp.hdr);
                    check_equal("pkt.data", pkt[d].data, exp.data);
                    check_equal("pkt.nwords", pkt[d].nwords, exp.nwords);
                end
                repeat ($urandom_range(0, MAX_DELAY)) @(posedge clk_bus);
                read[d] <= 1'b1;
                read_at[d][n_arr[d]] = cycle;
                n_arr[d]++;
                @(posedge clk_bus);
                read[d] <= 1'b0;
                @(posedge clk_bus);
                check_equal("full", full[d], 1'b0);   // Falls one cycle after read
                delivered++;
            end
        end
    endtask

    task automatic random_traffic(input int src);
        int at;
        for (int i = 0; i < RAND_PKTS / bus_pkg::N_SRC; i++) begin
            repeat ($urandom_range(0, MAX_GAP)) @(posedge clk_bus);
            send_pkt(src, rand_req(src, $urandom_range(0, bus_pkg::N_DES - 1),
                                   $urandom_range(1, bus_pkg::SLOTS)), at);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        bus_pkg::pkt_req_t r;
        bus_pkg::pkt_req_t r2;
        int at;
        int at2;
        int base;
        int first;
        int rr_last;
        void'($urandom(32'h90f83573));
        send = '0;
        read = '0;
        for (int i = 0; i < bus_pkg::N_SRC; i++) begin
            req[i] = '0;
        end
        for (int d = 0; d < bus_pkg::N_DES; d++) begin
            line_model[d] = '0;   // Buffers start empty after reset
        end
        wait (rst_n === 1'b1);
        @(posedge clk_bus);
        fork
            serve_dest(0);
            serve_dest(1);
        join_none

        check_equal("busy", busy, '0);
        for (int d = 0; d < bus_pkg::N_DES; d++) begin
            check_equal("full", full[d], 1'b0);
            check_equal("pkt", pkt[d], '0);
        end
        r = rand_req(0, 0, 4);
        send_pkt(0, r, at);
        wait_all();
        check_equal("latency", rise_at[0][0] - at, 3 + 4);
        report_test("reset and single packet");

        for (int n = 3; n >= 1; n--) begin
            send_pkt(0, rand_req(0, 0, n), at);
            wait_all();
        end
        report_test("short packets keep upper slots");

        r  = rand_req(0, 0, $urandom_range(1, bus_pkg::SLOTS));
        r2 = rand_req(1, 1, $urandom_range(1, bus_pkg::SLOTS));
        fork
            send_pkt(0, r, at);
            send_pkt(1, r2, at2);
        join
        wait_all();
        report_test("two sources, two destinations");

        rr_last = 0;   // Source 0 won last in test 3
        for (int k = 0; k < ROUNDS; k++) begin
            base = n_arr[1];
            r  = rand_req(0, 1, $urandom_range(1, bus_pkg::SLOTS));
            r2 = rand_req(1, 1, $urandom_range(1, bus_pkg::SLOTS));
            fork
                send_pkt(0, r, at);
                send_pkt(1, r2, at2);
            join
            wait_all();
            first = (rr_last + 1) % bus_pkg::N_SRC;
            check_equal("first source", arr_src[1][base], first);
            check_equal("second source", arr_src[1][base + 1], 1 - first);
            check_equal("second after read", rise_at[1][base + 1] > read_at[1][base], 1'b1);
            rr_last = 1 - first;
        end
        report_test("shared destination round-robin");

        fork
            random_traffic(0);
            random_traffic(1);
        join
        wait_all();
        for (int s = 0; s < bus_pkg::N_SRC; s++) begin
            check_equal("pending packets", tail[s] - head[s], 0);
        end
        report_test("random traffic");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
design/bus_pkg.sv
design/bus_src.sv
design/bus_arbiter.sv
design/bus_des.sv
design/bus_top.sv
bench/tb_clock.sv
bench/bus_asserts.sv
bench/bus_tb.sv

// File: Bender.yml
package:
  name: packet_bus

sources:
  - files:
      - design/bus_pkg.sv
      - design/bus_src.sv
      - design/bus_arbiter.sv
      - design/bus_des.sv
      - design/bus_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/bus_asserts.sv
      - bench/bus_tb.sv
